// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Width of addresses, PCs and instruction words
`define FETCH_XLEN 32

// First address fetched after reset_n or sys_reset
`define FETCH_START_ADDR 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Instruction length code from the two low opcode bits
    typedef enum logic [1:0] {
        LEN_16 = 2'b00,
        LEN_32 = 2'b11
    } instr_len_e;

    // Only 2'b11 marks a full 32-bit instruction
    function automatic instr_len_e instr_len_of(input logic [1:0] low_bits);
        instr_len_e len;
        if (low_bits == 2'b11)
            len = LEN_32;
        else
            len = LEN_16;
        return len;
    endfunction

endpackage

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // Reason behind the next fetch address
    typedef enum logic [2:0] {
        // Sequential, address plus four
        RD_ADVANCE    = 3'd0,
        // Trap or interrupt entry from the core
        RD_CTX_SWITCH = 3'd1,
        // Taken jump or branch from execute
        RD_JUMP       = 3'd2,
        // Branch predicted taken in decode
        RD_PREDICT    = 3'd3,
        // Wrong prediction, back to the saved address
        RD_ROLLBACK   = 3'd4
    } redirect_e;

endpackage

// ==== rtl/fetch_redirect.sv ====
`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_redirect
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,

    input  logic                   jump_i,
    input  logic [`FETCH_XLEN-1:0] jump_target_i,
    input  logic                   ctx_switch_i,
    input  logic [`FETCH_XLEN-1:0] ctx_switch_target_i,
    input  logic                   bp_take_i,
    input  logic [`FETCH_XLEN-1:0] bp_target_i,
    input  logic                   jump_rollback_i,

    output logic [`FETCH_XLEN-1:0] instruction_address_o,
    output logic                   redirect_o
);

    ////////////////////
    // Reason and target
    ////////////////////

    redirect_e               reason;
    logic [`FETCH_XLEN-1:2] iaddr_advance;
    logic [`FETCH_XLEN-1:2] iaddr_rollback;
    logic [`FETCH_XLEN-1:2] iaddr_next;

    assign iaddr_advance = instruction_address_o[`FETCH_XLEN-1:2] + 1'b1;

    // Context switch wins over everything else
    always_comb begin
        if (ctx_switch_i)
            reason = RD_CTX_SWITCH;
        else if (jump_i)
            reason = RD_JUMP;
        else if (jump_rollback_i)
            reason = RD_ROLLBACK;
        else if (enable_i && bp_take_i)
            reason = RD_PREDICT;
        else
            reason = RD_ADVANCE;
    end

    always_comb begin
        case (reason)
            RD_CTX_SWITCH: iaddr_next = ctx_switch_target_i[`FETCH_XLEN-1:2];
            RD_JUMP:       iaddr_next = jump_target_i[`FETCH_XLEN-1:2];
            RD_ROLLBACK:   iaddr_next = iaddr_rollback;
            RD_PREDICT:    iaddr_next = bp_target_i[`FETCH_XLEN-1:2];
            default:       iaddr_next = iaddr_advance;
        endcase
    end

    // A prediction only counts while the pipeline moves
    assign redirect_o = ctx_switch_i || jump_i || (enable_i && bp_take_i);

    ////////////////////
    // Address register
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_address_o <= `FETCH_START_ADDR;
        end else if (sys_reset_i) begin
            instruction_address_o <= `FETCH_START_ADDR;
        end else if (redirect_o || jump_rollback_i || enable_i) begin
            instruction_address_o <= {iaddr_next, 2'b00};
        end
    end

    // Word after the predicted branch, target of a later rollback
    always_ff @(posedge clk) begin
        if (enable_i && bp_take_i) begin
            iaddr_rollback <= iaddr_advance;
        end
    end

endmodule

// ==== rtl/fetch_jump_ctrl.sv ====
`timescale 1ns/100ps

module fetch_jump_ctrl
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic sys_reset_i,
    input  logic enable_i,
    input  logic redirect_i,
    input  logic jump_rollback_i,

    output logic jumping_o,
    output logic bp_rollback_o,
    output logic jumped_r_o
);

    redirect_e flag_event;
    logic      rollback_pending;

    // Reason is not visible here, any redirect is handled as a jump
    always_comb begin
        if (redirect_i)
            flag_event = RD_JUMP;
        else if (jump_rollback_i)
            flag_event = RD_ROLLBACK;
        else
            flag_event = RD_ADVANCE;
    end

    ////////////////////
    // Bubble flags
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r_o <= 1'b1;
            jumping_o  <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r_o <= 1'b1;
            jumping_o  <= 1'b1;
        end else begin
            case (flag_event)
                RD_JUMP: begin
                    jumped_r_o <= 1'b1;
                    jumping_o  <= 1'b1;
                end
                RD_ROLLBACK: begin
                    jumped_r_o <= 1'b0;
                    jumping_o  <= 1'b0;
                end
                default: begin
                    if (enable_i)
                        jumped_r_o <= 1'b0;
                    // Stays up one more enabled edge for the stale output
                    if (enable_i && !jumped_r_o)
                        jumping_o <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////
    // Rollback marker
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_pending <= 1'b0;
            bp_rollback_o    <= 1'b0;
        end else if (sys_reset_i) begin
            rollback_pending <= 1'b0;
            bp_rollback_o    <= 1'b0;
        end else begin
            if (jump_rollback_i)
                rollback_pending <= 1'b1;
            else if (enable_i)
                rollback_pending <= 1'b0;
            if (enable_i)
                bp_rollback_o <= rollback_pending;
        end
    end

endmodule

// ==== rtl/fetch_data_path.sv ====
`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_data_path
    import rv_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,
    input  logic                   jumped_r_i,
    input  logic [`FETCH_XLEN-1:0] instruction_address_i,
    input  logic [`FETCH_XLEN-1:0] instruction_data_i,

    output logic [`FETCH_XLEN-1:0] pc_o,
    output logic [`FETCH_XLEN-1:0] instruction_o,
    output logic                   compressed_o
);

    logic                   enable_r;
    logic [`FETCH_XLEN-1:0] idata_held;
    logic [`FETCH_XLEN-1:0] idata_fetched;
    logic [`FETCH_XLEN-1:0] pc_fetched;

    ////////////////////
    // Stall hold
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            enable_r <= 1'b0;
        else
            enable_r <= enable_i;
    end

    // Memory answers the last address even in the first stalled cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            idata_held <= `FETCH_NOP;
        else if (!enable_i && enable_r)
            idata_held <= instruction_data_i;
    end

    assign idata_fetched = enable_r ? instruction_data_i : idata_held;

    ////////////////////
    // PC pipeline
    ////////////////////

    // Stage one also follows a redirect while stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            pc_fetched <= '0;
        else if (jumped_r_i || enable_i)
            pc_fetched <= instruction_address_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            pc_o <= '0;
        else if (enable_i)
            pc_o <= pc_fetched;
    end

    // Instruction register and length flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= `FETCH_NOP;
            compressed_o  <= 1'b0;
        end else if (sys_reset_i) begin
            instruction_o <= `FETCH_NOP;
            compressed_o  <= 1'b0;
        end else if (enable_i) begin
            instruction_o <= idata_fetched;
            compressed_o  <= (instr_len_of(idata_fetched[1:0]) != LEN_32);
        end
    end

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,

    input  logic                   jump_i,
    input  logic [`FETCH_XLEN-1:0] jump_target_i,
    input  logic                   ctx_switch_i,
    input  logic [`FETCH_XLEN-1:0] ctx_switch_target_i,
    output logic                   jumping_o,

    input  logic                   bp_take_i,
    input  logic [`FETCH_XLEN-1:0] bp_target_i,
    input  logic                   jump_rollback_i,
    output logic                   bp_rollback_o,

    // Instruction memory side
    output logic [`FETCH_XLEN-1:0] instruction_address_o,
    input  logic [`FETCH_XLEN-1:0] instruction_data_i,

    // Towards decode
    output logic [`FETCH_XLEN-1:0] pc_o,
    output logic [`FETCH_XLEN-1:0] instruction_o,
    output logic                   compressed_o
);

    logic redirect;
    logic jumped_r;

    fetch_redirect u_redirect (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_i          (ctx_switch_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .bp_take_i             (bp_take_i),
        .bp_target_i           (bp_target_i),
        .jump_rollback_i       (jump_rollback_i),
        .instruction_address_o (instruction_address_o),
        .redirect_o            (redirect)
    );

    fetch_jump_ctrl u_jump_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .enable_i        (enable_i),
        .redirect_i      (redirect),
        .jump_rollback_i (jump_rollback_i),
        .jumping_o       (jumping_o),
        .bp_rollback_o   (bp_rollback_o),
        .jumped_r_o      (jumped_r)
    );

    fetch_data_path u_data_path (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jumped_r_i            (jumped_r),
        .instruction_address_i (instruction_address_o),
        .instruction_data_i    (instruction_data_i),
        .pc_o                  (pc_o),
        .instruction_o         (instruction_o),
        .compressed_o          (compressed_o)
    );

endmodule

// ==== dv/fetch_imem_model.sv ====
`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_imem_model (
    input  logic                   clk,
    input  logic [`FETCH_XLEN-1:0] addr_i,
    output logic [`FETCH_XLEN-1:0] data_o
);

    // Word is a fixed scramble of its own address
    function automatic logic [`FETCH_XLEN-1:0] word_at(input logic [`FETCH_XLEN-1:0] addr);
        logic [`FETCH_XLEN-1:0] w;
        w = {addr[24:0], addr[31:25]} ^ 32'h5a3c_96e1;
        // Every eighth word reads as a 16-bit opcode
        w[1:0] = (addr[4:2] == 3'b000) ? 2'b01 : 2'b11;
        return w;
    endfunction

    initial data_o = `FETCH_NOP;

    // One clock of read latency
    always @(posedge clk) begin
        data_o <= word_at(addr_i);
    end

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_tb
    import rv_isa_pkg::*;
();

    // Cycle budget of each test
    localparam int SEQ_CYCLES     = 40;
    localparam int STALL_CYCLES   = 140;
    localparam int JUMP_CYCLES    = 40;
    localparam int PREDICT_CYCLES = 40;
    localparam int SOFT_CYCLES    = 50;
    localparam int TIMEOUT_CYCLES =
        2 * (SEQ_CYCLES + STALL_CYCLES + JUMP_CYCLES + PREDICT_CYCLES + SOFT_CYCLES);

    logic        clk, reset_n, sys_reset_i, enable_i;
    logic        jump_i, ctx_switch_i, bp_take_i, jump_rollback_i;
    logic [31:0] jump_target_i, ctx_switch_target_i, bp_target_i;
    logic        jumping_o, bp_rollback_o, compressed_o;
    logic [31:0] instruction_address_o, instruction_data_i, pc_o, instruction_o;

    logic [31:0] lfsr_state;
    logic [31:0] prev_pc;
    logic        have_prev;
    logic        cycle_valid;
    int          cycles = 0;
    int          errors = 0;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fetch_top uut (.*);

    fetch_imem_model u_imem (
        .clk    (clk),
        .addr_i (instruction_address_o),
        .data_o (instruction_data_i)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Address rotated left by 7, scrambled, low bits give the length
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] w;
        w = {addr[24:0], addr[31:25]} ^ 32'h5a3c_96e1;
        w[1:0] = (addr[4:2] == 3'b000) ? 2'b01 : 2'b11;
        return w;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_target(output logic [31:0] target);
        logic [31:0] r;
        draw_bits(12, r);
        target = 32'h0000_4000 + {r[29:0], 2'b00};
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Outputs are registered, so they are stable 1 ns after the edge
    task automatic next_cycle(input logic en);
        @(posedge clk);
        #1;
        enable_i        = en;
        jump_i          = 1'b0;
        ctx_switch_i    = 1'b0;
        bp_take_i       = 1'b0;
        jump_rollback_i = 1'b0;
        sys_reset_i     = 1'b0;
        cycle_valid     = en && !jumping_o;
    endtask

    task automatic next_output(input logic random_stall);
        logic [31:0] r;
        logic        en;
        cycle_valid = 1'b0;
        while (!cycle_valid) begin
            en = 1'b1;
            if (random_stall) begin
                draw_bits(1, r);
                en = r[0];
            end
            next_cycle(en);
        end
    endtask

    // Word, length flag and gap-free PC order of one valid output
    task automatic check_stream_output();
        logic [31:0] exp_instr;
        instr_len_e  exp_len;
        exp_instr = expected_word(pc_o);
        exp_len = (exp_instr[1:0] == 2'b11) ? LEN_32 : LEN_16;
        compare_value("instruction_o", exp_instr, instruction_o);
        compare_value("compressed_o", exp_len != LEN_32, compressed_o);
        if (have_prev)
            compare_value("pc_o", prev_pc + 32'd4, pc_o);
        prev_pc   = pc_o;
        have_prev = 1'b1;
    endtask

    task automatic expect_redirect(input logic [31:0] target);
        have_prev = 1'b0;
        next_cycle(1'b1);
        compare_value("jumping_o", 1'b1, jumping_o);
        next_output(1'b0);
        compare_value("pc_o", target, pc_o);
        check_stream_output();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic reset_and_sequential();
        compare_value("instruction_address_o", `FETCH_START_ADDR, instruction_address_o);
        compare_value("jumping_o", 1'b1, jumping_o);
        compare_value("pc_o", 32'h0, pc_o);
        compare_value("instruction_o", `FETCH_NOP, instruction_o);
        next_output(1'b0);
        compare_value("pc_o", `FETCH_START_ADDR, pc_o);
        check_stream_output();
        repeat (23) begin
            next_output(1'b0);
            check_stream_output();
        end
    endtask

    task automatic stall_sequence();
        repeat (40) begin
            next_output(1'b1);
            check_stream_output();
        end
    endtask

    task automatic jump_priority();
        logic [31:0] jump_t;
        logic [31:0] ctx_t;
        draw_target(jump_t);
        next_cycle(1'b1);
        if (cycle_valid)
            check_stream_output();
        jump_i        = 1'b1;
        jump_target_i = jump_t;
        expect_redirect(jump_t);
        repeat (4) begin
            next_output(1'b0);
            check_stream_output();
        end
        // Both at once, the context switch wins
        draw_target(jump_t);
        draw_target(ctx_t);
        next_cycle(1'b1);
        if (cycle_valid)
            check_stream_output();
        jump_i              = 1'b1;
        jump_target_i       = jump_t;
        ctx_switch_i        = 1'b1;
        ctx_switch_target_i = ctx_t;
        expect_redirect(ctx_t);
    endtask

    task automatic predict_and_rollback();
        logic [31:0] bp_t;
        logic [31:0] saved_addr;
        logic [31:0] rollback_addr;
        draw_target(bp_t);
        next_cycle(1'b1);
        if (cycle_valid)
            check_stream_output();
        saved_addr  = instruction_address_o;
        bp_take_i   = 1'b1;
        bp_target_i = bp_t;
        expect_redirect(bp_t);
        repeat (3) begin
            next_output(1'b0);
            check_stream_output();
        end
        next_cycle(1'b1);
        if (cycle_valid)
            check_stream_output();
        rollback_addr   = instruction_address_o;
        jump_rollback_i = 1'b1;
        // No bubble, the marker rides on the word fetched in the rollback cycle
        next_output(1'b0);
        compare_value("bp_rollback_o", 1'b0, bp_rollback_o);
        check_stream_output();
        next_output(1'b0);
        compare_value("bp_rollback_o", 1'b1, bp_rollback_o);
        compare_value("pc_o", rollback_addr, pc_o);
        check_stream_output();
        next_output(1'b0);
        compare_value("bp_rollback_o", 1'b0, bp_rollback_o);
        compare_value("pc_o", saved_addr + 32'd4, pc_o);
        have_prev = 1'b0;
        check_stream_output();
    endtask

    task automatic length_and_soft_reset();
        int compressed_count;
        compressed_count = 0;
        repeat (16) begin
            next_output(1'b0);
            check_stream_output();
            if (compressed_o)
                compressed_count++;
        end
        compare_value("compressed_o count", 32'd2, compressed_count);
        // Pending rollback must not survive the soft reset
        next_cycle(1'b1);
        jump_rollback_i = 1'b1;
        next_cycle(1'b1);
        sys_reset_i = 1'b1;
        next_cycle(1'b1);
        compare_value("instruction_address_o", `FETCH_START_ADDR, instruction_address_o);
        compare_value("jumping_o", 1'b1, jumping_o);
        compare_value("bp_rollback_o", 1'b0, bp_rollback_o);
        compare_value("instruction_o", `FETCH_NOP, instruction_o);
        compare_value("compressed_o", 1'b0, compressed_o);
        have_prev = 1'b0;
        next_output(1'b0);
        compare_value("pc_o", `FETCH_START_ADDR, pc_o);
        check_stream_output();
        repeat (8) begin
            next_output(1'b0);
            check_stream_output();
        end
    endtask

    initial begin
        reset_n             = 1'b0;
        sys_reset_i         = 1'b0;
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        jump_target_i       = '0;
        ctx_switch_i        = 1'b0;
        ctx_switch_target_i = '0;
        bp_take_i           = 1'b0;
        bp_target_i         = '0;
        jump_rollback_i     = 1'b0;
        lfsr_state          = 32'h5379;
        have_prev           = 1'b0;
        cycle_valid         = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        reset_and_sequential();
        stall_sequence();
        jump_priority();
        predict_and_rollback();
        length_and_soft_reset();
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_redirect.sv
rtl/fetch_jump_ctrl.sv
rtl/fetch_data_path.sv
rtl/fetch_top.sv
dv/fetch_imem_model.sv
dv/fetch_tb.sv
